/* mania_core.f */
rtl/mania_core_pkg.sv
rtl/segment_size_scanner.sv
rtl/timing_header_reader.sv
rtl/audio_pacer.sv
rtl/core_sequencer.sv
rtl/mania_core.sv
verif/tb_clock_gen.sv
verif/chart_mem_model.sv
verif/mania_core_assert.sv
verif/mania_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the mania_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mania_core_tb -Mdir obj_dir -f mania_core.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vmania_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* verif/mania_core_tb.sv */
/*
 * Testbench top for the chart timing core.
 * Loads random chart headers, checks the tables once run is reached,
 * then answers song requests; bound assertions watch the protocol.
 */

`timescale 1ns/1ps

module mania_core_tb;

	localparam int UPDATE_PERIOD = 10;
	localparam int AUDIO_PERIOD = 4;
	localparam int PLAY_DELAY = 200;
	localparam int REQ_TARGET = 40;
	localparam int SCAN_CYCLES = 17 + 65 + 17 + 9 + 8;
	localparam int TIMEOUT_CYCLES = 2 * (SCAN_CYCLES + PLAY_DELAY + REQ_TARGET * AUDIO_PERIOD);

	logic CLK;
	logic RESET_L;
	logic [23:0] beatmap_q;
	logic [3:0] object_q;
	logic [31:0] pixel_q;
	logic [31:0] timing_q;
	logic [7:0] song_data;
	logic song_ready;
	mania_core_pkg::rd_req_t beatmap_rd, object_rd, pixel_rd, timing_rd;
	mania_core_pkg::seg_table_t beatmap_table, object_table, pixel_table;
	mania_core_pkg::seg_table_t exp_beatmap, exp_object, exp_pixel;
	mania_core_pkg::timing_info_t timing_info, exp_timing;
	mania_core_pkg::core_state_t core_state;
	logic song_request, update_tick, audio_en;
	logic [7:0] main_audio_out;
	logic [15:0] lfsr;
	int req_count;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) clk_gen (.CLK(CLK), .RESET_L(RESET_L));

	chart_mem_model #(.DATA_W(24)) beatmap_mem (.CLK(CLK), .rd(beatmap_rd), .q(beatmap_q));
	chart_mem_model #(.DATA_W(4)) object_mem (.CLK(CLK), .rd(object_rd), .q(object_q));
	chart_mem_model #(.DATA_W(32)) pixel_mem (.CLK(CLK), .rd(pixel_rd), .q(pixel_q));
	chart_mem_model #(.DATA_W(32)) timing_mem (.CLK(CLK), .rd(timing_rd), .q(timing_q));

	mania_core #(
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.AUDIO_PERIOD(AUDIO_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) DUT (
		.CLK(CLK), .RESET_L(RESET_L),
		.beatmap_q(beatmap_q), .object_q(object_q), .pixel_q(pixel_q), .timing_q(timing_q),
		.song_data(song_data), .song_ready(song_ready),
		.beatmap_rd(beatmap_rd), .object_rd(object_rd), .pixel_rd(pixel_rd),
		.timing_rd(timing_rd),
		.beatmap_table(beatmap_table), .object_table(object_table), .pixel_table(pixel_table),
		.timing_info(timing_info), .core_state(core_state),
		.song_request(song_request), .update_tick(update_tick), .audio_en(audio_en),
		.main_audio_out(main_audio_out)
	);

	task automatic stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on error");
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic random_size(output mania_core_pkg::chart_addr_t s);
		logic [31:0] v;
		do
			v = random_bits(5);
		while (v == 0);
		s = v[12:0];
	endtask

	// folds every address bit into the word
	function automatic logic [31:0] background_word(input int addr, input int w);
		logic [31:0] p;
		p = 32'h5A00_0000;
		for (int sh = 0; sh < 13; sh += w)
			p = p ^ (32'(addr) >> sh);
		return p;
	endfunction

	task automatic write_word(input int which, input mania_core_pkg::chart_addr_t addr,
		input logic [31:0] data);
		case (which)
			0: beatmap_mem.mem[addr] = data[23:0];
			1: object_mem.mem[addr] = data[3:0];
			2: pixel_mem.mem[addr] = data;
			default: timing_mem.mem[addr] = data;
		endcase
	endtask

	task automatic fill_background();
		logic [31:0] p;
		for (int a = 0; a < 8192; a++) begin
			p = background_word(a, 24);
			write_word(0, 13'(a), p);
			p = background_word(a, 4);
			write_word(1, 13'(a), p);
			p = background_word(a, 32);
			write_word(2, 13'(a), p);
			write_word(3, 13'(a), p);
		end
	endtask

	// headers chained after each segment with the expected table built alongside
	task automatic build_table(input int parts, input int part_w, input int which,
		output mania_core_pkg::seg_table_t t);
		mania_core_pkg::chart_addr_t hdr;
		mania_core_pkg::chart_addr_t s;
		logic [31:0] word;
		t = '0;
		for (int seg = 0; seg < mania_core_pkg::SEG_COUNT; seg++) begin
			if (seg == 0)
				hdr = '0;
			else
				hdr = t.base[seg - 1] + t.size[seg - 1];
			random_size(s);
			for (int p = 0; p < parts; p++) begin
				word = 32'(s) >> (p * part_w);
				write_word(which, hdr + 13'(p), word);
			end
			t.base[seg] = hdr + 13'(parts);
			t.size[seg] = s;
		end
	endtask

	task automatic compare_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	initial begin
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] wait_bits;
		logic [31:0] sample;
		song_ready = 1'b0;
		song_data = '0;
		lfsr = 16'd79;
		req_count = 0;
		fill_background();
		build_table(1, 24, 0, exp_beatmap);
		build_table(4, 4, 1, exp_object);
		build_table(1, 32, 2, exp_pixel);
		w0 = random_bits(32);
		w1 = random_bits(32);
		write_word(3, 13'd0, w0);
		write_word(3, 13'd1, w1);
		exp_timing.table_size = w0[11:0];
		exp_timing.song_length = w1[19:0];

		wait (RESET_L);
		do
			@(negedge CLK);
		while (core_state != mania_core_pkg::s_run);
		compare_value("beatmap_table", 128'(exp_beatmap), 128'(beatmap_table));
		compare_value("object_table", 128'(exp_object), 128'(object_table));
		compare_value("pixel_table", 128'(exp_pixel), 128'(pixel_table));
		compare_value("timing_info", 128'(exp_timing), 128'(timing_info));

		// answer each request after 0 to 2 cycles
		while (req_count < REQ_TARGET) begin
			@(negedge CLK);
			if (song_request) begin
				wait_bits = random_bits(2);
				repeat (wait_bits % 3) @(negedge CLK);
				sample = random_bits(8);
				song_ready = 1'b1;
				song_data = sample[7:0];
				@(negedge CLK);
				song_ready = 1'b0;
				req_count++;
			end
		end
		if (DUT.u_assert.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("a protocol assertion in the core failed");
			stop_with_failure();
		end
	end

	always @(negedge CLK) begin
		if (DUT.u_assert.fail_count != 0) begin
			$display("a protocol assertion in the core failed");
			stop_with_failure();
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout, the song requests did not all arrive in time");
		stop_with_failure();
	end

endmodule

/* verif/mania_core_assert.sv */
/*
 * Protocol checks bound into the core top level.
 * Read port ownership, song request pacing, tick spacing and sample latch.
 */

`timescale 1ns/1ps

module mania_core_assert #(
	parameter int UPDATE_PERIOD = 10,
	parameter int AUDIO_PERIOD = 4,
	parameter int PLAY_DELAY = 200
) (
	input logic CLK,
	input logic RESET_L,
	input mania_core_pkg::rd_req_t beatmap_rd,
	input mania_core_pkg::rd_req_t object_rd,
	input mania_core_pkg::rd_req_t pixel_rd,
	input mania_core_pkg::rd_req_t timing_rd,
	input mania_core_pkg::core_state_t core_state,
	input logic song_request,
	input logic update_tick,
	input logic audio_en,
	input logic song_ready,
	input logic [mania_core_pkg::SAMPLE_W-1:0] song_data,
	input logic [mania_core_pkg::SAMPLE_W-1:0] main_audio_out
);

	int cyc; // saturating count of cycles since reset
	int req_gap;
	int tick_gap; // cycles since the last tick, counted in run
	logic seen_req;
	logic seen_tick;
	int fail_count = 0;
	logic [3:0] ens;

	assign ens = {beatmap_rd.en, object_rd.en, pixel_rd.en, timing_rd.en};

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			cyc <= 0;
			req_gap <= 0;
			tick_gap <= 0;
			seen_req <= 1'b0;
			seen_tick <= 1'b0;
		end else begin
			if (cyc <= PLAY_DELAY)
				cyc <= cyc + 1;
			if (song_request) begin
				req_gap <= 1;
				seen_req <= 1'b1;
			end else if (seen_req)
				req_gap <= req_gap + 1;
			if (update_tick) begin
				tick_gap <= 1;
				seen_tick <= 1'b1;
			end else if (core_state == mania_core_pkg::s_run)
				tick_gap <= tick_gap + 1;
		end
	end

	a_enable_onehot: assert property (@(posedge CLK) disable iff (!RESET_L) $onehot0(ens))
		else begin
			fail_count = fail_count + 1;
			$error("more than one read port enabled");
		end

	a_beatmap_owner: assert property (@(posedge CLK) disable iff (!RESET_L)
		beatmap_rd.en |-> core_state == mania_core_pkg::s_scan_beatmap)
		else begin
			fail_count = fail_count + 1;
			$error("beatmap read outside its scan");
		end

	a_object_owner: assert property (@(posedge CLK) disable iff (!RESET_L)
		object_rd.en |-> core_state == mania_core_pkg::s_scan_object)
		else begin
			fail_count = fail_count + 1;
			$error("object read outside its scan");
		end

	a_pixel_owner: assert property (@(posedge CLK) disable iff (!RESET_L)
		pixel_rd.en |-> core_state == mania_core_pkg::s_scan_pixel)
		else begin
			fail_count = fail_count + 1;
			$error("pixel read outside its scan");
		end

	a_timing_owner: assert property (@(posedge CLK) disable iff (!RESET_L)
		timing_rd.en |-> core_state == mania_core_pkg::s_scan_timing)
		else begin
			fail_count = fail_count + 1;
			$error("timing read outside its scan");
		end

	// registers come out of reset idle
	a_reset_idle: assert property (@(posedge CLK) !RESET_L |=> ens == 4'b0)
		else begin
			fail_count = fail_count + 1;
			$error("read enable high after reset");
		end

	a_req_window: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request |-> cyc > PLAY_DELAY && core_state == mania_core_pkg::s_run)
		else begin
			fail_count = fail_count + 1;
			$error("song request too early or outside run");
		end

	a_req_spacing: assert property (@(posedge CLK) disable iff (!RESET_L)
		seen_req |-> song_request == (req_gap == AUDIO_PERIOD))
		else begin
			fail_count = fail_count + 1;
			$error("song requests not one audio period apart");
		end

	a_tick_spacing: assert property (@(posedge CLK) disable iff (!RESET_L)
		seen_tick |-> update_tick == (tick_gap == UPDATE_PERIOD))
		else begin
			fail_count = fail_count + 1;
			$error("update ticks not one period apart");
		end

	a_tick_alive: assert property (@(posedge CLK) disable iff (!RESET_L)
		tick_gap <= UPDATE_PERIOD)
		else begin
			fail_count = fail_count + 1;
			$error("update tick missing in run");
		end

	a_audio_en: assert property (@(posedge CLK) disable iff (!RESET_L)
		audio_en == (core_state == mania_core_pkg::s_run))
		else begin
			fail_count = fail_count + 1;
			$error("audio_en does not follow run");
		end

	a_sample_latch: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_ready |=> main_audio_out == $past(song_data))
		else begin
			fail_count = fail_count + 1;
			$error("sample not latched on song_ready");
		end

endmodule

bind mania_core mania_core_assert #(
	.UPDATE_PERIOD(UPDATE_PERIOD),
	.AUDIO_PERIOD(AUDIO_PERIOD),
	.PLAY_DELAY(PLAY_DELAY)
) u_assert (
	.CLK(CLK), .RESET_L(RESET_L),
	.beatmap_rd(beatmap_rd), .object_rd(object_rd),
	.pixel_rd(pixel_rd), .timing_rd(timing_rd),
	.core_state(core_state), .song_request(song_request),
	.update_tick(update_tick), .audio_en(audio_en),
	.song_ready(song_ready), .song_data(song_data),
	.main_audio_out(main_audio_out)
);

/* verif/chart_mem_model.sv */
/*
 * Read-only chart memory with one cycle of read latency.
 * The testbench writes the contents into mem before reset is released.
 */

`timescale 1ns/1ps

module chart_mem_model #(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 13
) (
	input logic CLK,
	input mania_core_pkg::rd_req_t rd,
	output logic [DATA_W-1:0] q
);

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

	initial q = '0;

	always_ff @(posedge CLK) begin
		if (rd.en)
			q <= mem[rd.addr[ADDR_W-1:0]]; // word valid the next cycle
	end

endmodule

/* verif/tb_clock_gen.sv */
/*
 * Clock and reset source for the testbench.
 * Holds RESET_L low for RESET_CYCLES clocks, released on a falling edge.
 */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic RESET_L
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		RESET_L = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RESET_L = 1'b1;
	end

endmodule

/* rtl/mania_core.sv */
/*
 * Top level of the chart timing core.
 * Scans the preloaded chart memories after reset, exports their tables,
 * then runs the update tick and the song sample path.
 */

`timescale 1ns/1ps

module mania_core #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD = 2267,
	parameter int PLAY_DELAY = 1500
) (
	input logic CLK,
	input logic RESET_L,
	input logic [23:0] beatmap_q,
	input logic [3:0] object_q,
	input logic [31:0] pixel_q,
	input logic [31:0] timing_q,
	input logic [mania_core_pkg::SAMPLE_W-1:0] song_data,
	input logic song_ready,
	output mania_core_pkg::rd_req_t beatmap_rd,
	output mania_core_pkg::rd_req_t object_rd,
	output mania_core_pkg::rd_req_t pixel_rd,
	output mania_core_pkg::rd_req_t timing_rd,
	output mania_core_pkg::seg_table_t beatmap_table,
	output mania_core_pkg::seg_table_t object_table,
	output mania_core_pkg::seg_table_t pixel_table,
	output mania_core_pkg::timing_info_t timing_info,
	output mania_core_pkg::core_state_t core_state,
	output logic song_request,
	output logic update_tick,
	output logic audio_en,
	output logic [mania_core_pkg::SAMPLE_W-1:0] main_audio_out
);

	logic beatmap_start, object_start, pixel_start, timing_start;
	logic beatmap_done, object_done, pixel_done, timing_done;
	logic running;

	core_sequencer u_seq (
		.CLK(CLK), .RESET_L(RESET_L),
		.beatmap_done(beatmap_done), .object_done(object_done),
		.pixel_done(pixel_done), .timing_done(timing_done),
		.beatmap_start(beatmap_start), .object_start(object_start),
		.pixel_start(pixel_start), .timing_start(timing_start),
		.running(running), .state(core_state)
	);

	// one size word per segment
	segment_size_scanner #(.PARTS(1), .PART_W(24)) u_beatmap_scan (
		.CLK(CLK), .RESET_L(RESET_L), .start(beatmap_start), .rd_data(beatmap_q),
		.rd(beatmap_rd), .seg_table(beatmap_table), .done(beatmap_done)
	);

	// sizes stored as four nibbles
	segment_size_scanner #(.PARTS(4), .PART_W(4)) u_object_scan (
		.CLK(CLK), .RESET_L(RESET_L), .start(object_start), .rd_data(object_q),
		.rd(object_rd), .seg_table(object_table), .done(object_done)
	);

	segment_size_scanner #(.PARTS(1), .PART_W(32)) u_pixel_scan (
		.CLK(CLK), .RESET_L(RESET_L), .start(pixel_start), .rd_data(pixel_q),
		.rd(pixel_rd), .seg_table(pixel_table), .done(pixel_done)
	);

	timing_header_reader u_timing_hdr (
		.CLK(CLK), .RESET_L(RESET_L), .start(timing_start), .rd_data(timing_q),
		.rd(timing_rd), .info(timing_info), .done(timing_done)
	);

	audio_pacer #(
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.AUDIO_PERIOD(AUDIO_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) u_pacer (
		.CLK(CLK), .RESET_L(RESET_L), .running(running),
		.song_ready(song_ready), .song_data(song_data),
		.update_tick(update_tick), .song_request(song_request),
		.audio_en(audio_en), .main_audio_out(main_audio_out)
	);

endmodule

/* rtl/core_sequencer.sv */
/*
 * Start-up and run FSM of the core.
 * Starts the beatmap, object, pixel and timing scans in turn, waiting for
 * each done pulse, then stays in run until reset.
 */

`timescale 1ns/1ps

module core_sequencer (
	input logic CLK,
	input logic RESET_L,
	input logic beatmap_done,
	input logic object_done,
	input logic pixel_done,
	input logic timing_done,
	output logic beatmap_start,
	output logic object_start,
	output logic pixel_start,
	output logic timing_start,
	output logic running,
	output mania_core_pkg::core_state_t state
);

	mania_core_pkg::core_state_t next;
	logic entering; // first cycle of the current state

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= mania_core_pkg::s_init;
			entering <= 1'b0;
		end else begin
			state <= next;
			entering <= next != state;
		end
	end

	always_comb begin
		next = state;
		case (state)
			mania_core_pkg::s_init:
				next = mania_core_pkg::s_scan_beatmap;
			mania_core_pkg::s_scan_beatmap:
				if (beatmap_done)
					next = mania_core_pkg::s_scan_object;
			mania_core_pkg::s_scan_object:
				if (object_done)
					next = mania_core_pkg::s_scan_pixel;
			mania_core_pkg::s_scan_pixel:
				if (pixel_done)
					next = mania_core_pkg::s_scan_timing;
			mania_core_pkg::s_scan_timing:
				if (timing_done)
					next = mania_core_pkg::s_run;
			mania_core_pkg::s_run:
				next = mania_core_pkg::s_run; // only reset leaves run
			default:
				next = mania_core_pkg::s_init;
		endcase
	end

	assign beatmap_start = entering && state == mania_core_pkg::s_scan_beatmap;
	assign object_start = entering && state == mania_core_pkg::s_scan_object;
	assign pixel_start = entering && state == mania_core_pkg::s_scan_pixel;
	assign timing_start = entering && state == mania_core_pkg::s_scan_timing;
	assign running = state == mania_core_pkg::s_run;

endmodule

/* rtl/audio_pacer.sv */
/*
 * Run-phase clocks of the core: update tick and audio sample clock.
 * After PLAY_DELAY cycles from reset it requests one song sample per
 * audio period and latches each returned sample onto the main output.
 */

`timescale 1ns/1ps

module audio_pacer #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD = 2267,
	parameter int PLAY_DELAY = 1500
) (
	input logic CLK,
	input logic RESET_L,
	input logic running,
	input logic song_ready,
	input logic [mania_core_pkg::SAMPLE_W-1:0] song_data,
	output logic update_tick,
	output logic song_request,
	output logic audio_en,
	output logic [mania_core_pkg::SAMPLE_W-1:0] main_audio_out
);

	localparam int UPD_W = (UPDATE_PERIOD > 1) ? $clog2(UPDATE_PERIOD) : 1;
	localparam int AUD_W = (AUDIO_PERIOD > 1) ? $clog2(AUDIO_PERIOD) : 1;
	localparam int DLY_W = $clog2(PLAY_DELAY + 1);

	logic [UPD_W-1:0] update_cnt;
	logic [AUD_W-1:0] audio_cnt;
	logic [DLY_W-1:0] delay_cnt;
	logic update_last;
	logic audio_last;
	logic delay_reached;

	assign update_last = update_cnt == UPD_W'(UPDATE_PERIOD - 1);
	assign audio_last = audio_cnt == AUD_W'(AUDIO_PERIOD - 1);
	assign delay_reached = delay_cnt == DLY_W'(PLAY_DELAY);

	assign update_tick = running && update_last;
	assign audio_en = running;

	// counters only advance in run
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			update_cnt <= '0;
			audio_cnt <= '0;
		end else if (running) begin
			update_cnt <= update_last ? '0 : update_cnt + 1'b1;
			audio_cnt <= audio_last ? '0 : audio_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			delay_cnt <= '0;
			song_request <= 1'b0;
		end else begin
			if (!delay_reached)
				delay_cnt <= delay_cnt + 1'b1; // saturates at PLAY_DELAY
			song_request <= delay_reached && running && audio_last;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			main_audio_out <= '0;
		else if (song_ready)
			main_audio_out <= song_data;
	end

endmodule

/* rtl/timing_header_reader.sv */
/*
 * Reads the two header words of the timing memory.
 * Word 0 is the timing table size, word 1 the song length.
 * Pulse start once; done pulses 9 cycles later.
 */

`timescale 1ns/1ps

module timing_header_reader (
	input logic CLK,
	input logic RESET_L,
	input logic start,
	input logic [31:0] rd_data,
	output mania_core_pkg::rd_req_t rd,
	output mania_core_pkg::timing_info_t info,
	output logic done
);

	logic active;
	logic [1:0] phase;
	logic word; // header word being read

	always_comb begin
		rd.en = active;
		rd.addr = mania_core_pkg::chart_addr_t'(word);
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			phase <= '0;
			word <= 1'b0;
			done <= 1'b0;
			info.table_size <= 12'd2; // table follows the two header words
			info.song_length <= '0;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start)
					active <= 1'b1;
			end else begin
				phase <= phase + 2'd1;
				if (phase == 2'd3) begin
					if (word) begin
						info.song_length <= rd_data[mania_core_pkg::SONG_LEN_W-1:0];
						active <= 1'b0;
						done <= 1'b1;
					end else begin
						info.table_size <= rd_data[mania_core_pkg::TIMING_SIZE_W-1:0];
					end
					word <= ~word;
				end
			end
		end
	end

endmodule

/* rtl/segment_size_scanner.sv */
/*
 * Walks the four segment headers of one chart memory and builds its
 * base/size table. A size is PARTS words of PART_W bits, low part first.
 * Pulse start once; done pulses 16*PARTS+1 cycles later.
 */

`timescale 1ns/1ps

module segment_size_scanner #(
	parameter int PARTS = 1,
	parameter int PART_W = 24
) (
	input logic CLK,
	input logic RESET_L,
	input logic start,
	input logic [PART_W-1:0] rd_data,
	output mania_core_pkg::rd_req_t rd,
	output mania_core_pkg::seg_table_t seg_table,
	output logic done
);

	localparam int PART_CNT_W = (PARTS > 1) ? $clog2(PARTS) : 1;
	localparam int SEG_IDX_W = $clog2(mania_core_pkg::SEG_COUNT);
	localparam int ACC_W = (PARTS * PART_W > mania_core_pkg::CHART_ADDR_W) ?
		PARTS * PART_W : mania_core_pkg::CHART_ADDR_W;

	logic active;
	logic [1:0] phase; // four cycles per header read
	logic [SEG_IDX_W-1:0] seg;
	logic [PART_CNT_W-1:0] part;
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_next;
	mania_core_pkg::chart_addr_t hdr_addr;
	logic last_part;
	logic last_seg;

	assign last_part = part == PART_CNT_W'(PARTS - 1);
	assign last_seg = seg == SEG_IDX_W'(mania_core_pkg::SEG_COUNT - 1);

	// header sits right after the previous segment
	always_comb begin
		if (seg == '0)
			hdr_addr = '0;
		else
			hdr_addr = seg_table.base[seg - 1'b1] + seg_table.size[seg - 1'b1];
	end

	always_comb begin
		rd.en = active;
		rd.addr = hdr_addr + mania_core_pkg::chart_addr_t'(part);
	end

	// merge the current word into the size being assembled
	always_comb begin
		acc_next = (part == '0) ? '0 : acc;
		for (int i = 0; i < PARTS; i++) begin
			if (part == PART_CNT_W'(i))
				acc_next[i * PART_W +: PART_W] = rd_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (active && phase == 2'd3)
			acc <= acc_next;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			phase <= '0;
			seg <= '0;
			part <= '0;
			done <= 1'b0;
			seg_table <= '0;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start)
					active <= 1'b1;
			end else begin
				phase <= phase + 2'd1;
				if (phase == 2'd3) begin // data settled by now
					if (last_part) begin
						seg_table.size[seg] <= acc_next[mania_core_pkg::CHART_ADDR_W-1:0];
						seg_table.base[seg] <= hdr_addr +
							mania_core_pkg::chart_addr_t'(PARTS);
						part <= '0;
						seg <= seg + 1'b1;
						if (last_seg) begin
							active <= 1'b0;
							done <= 1'b1;
						end
					end else begin
						part <= part + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* rtl/mania_core_pkg.sv */
/*
 * Shared types and widths of the chart timing core.
 * Read requests, segment tables, timing header and the sequencer
 * state encoding. Modules refer to these by scoped name.
 */

package mania_core_pkg;

	localparam int CHART_ADDR_W = 13; // object and timing use the low 12 bits
	localparam int SEG_COUNT = 4;
	localparam int SAMPLE_W = 8;
	localparam int TIMING_SIZE_W = 12;
	localparam int SONG_LEN_W = 20;

	typedef logic [CHART_ADDR_W-1:0] chart_addr_t;

	// one read port request
	typedef struct packed {
		logic en;
		chart_addr_t addr;
	} rd_req_t;

	// base and size of each chart segment
	typedef struct packed {
		chart_addr_t [SEG_COUNT-1:0] base;
		chart_addr_t [SEG_COUNT-1:0] size;
	} seg_table_t;

	typedef struct packed {
		logic [TIMING_SIZE_W-1:0] table_size;
		logic [SONG_LEN_W-1:0] song_length;
	} timing_info_t;

	typedef enum logic [3:0] {
		s_init = 4'h0,
		s_scan_beatmap = 4'h1,
		s_scan_object = 4'h2,
		s_scan_pixel = 4'h3,
		s_scan_timing = 4'h4,
		s_run = 4'h8 // game clocks on
	} core_state_t;

endpackage
